/* hdl/sensorI2cPkg.sv */
`default_nettype none

package sensorI2cPkg;

    // ====================
    // Bus field widths
    // ====================
    typedef logic [6:0]  slaveAddrT;
    typedef logic [15:0] regAddrT;
    // Low byte only in a one-byte access
    typedef logic [15:0] regDataT;

    // ====================
    // Master sequencer
    // ====================
    typedef enum logic [4:0] {
        StIdle, StStart, StAddrW,
        StShiftHi, StShiftHold, StShiftFall, StShiftNext,
        StAckHi, StAckSample, StAckFall,
        StRegHi, StRegLo, StDataHi, StDataLo,
        StRestartRel, StRestartHi, StRestartSda, StRestartLow, StAddrR,
        StReadRel, StReadHi, StReadSample, StReadFall,
        StMackDrive, StMackHi, StMackHold, StMackFall,
        StStopLow, StStopHi, StStopRel, StDone
    } masterStateT;

endpackage

`default_nettype wire

/* hdl/i2cCmdPort.sv */
`timescale 1ns/1ps
`default_nettype none

module i2cCmdPort
    import sensorI2cPkg::*;
(
    input  wire            clk,
    input  wire            rstN,
    // Client side, four-phase
    input  wire            req,
    output logic           ack,
    input  wire slaveAddrT slaveAddr,
    input  wire            write,
    input  wire regAddrT   regAddr,
    input  wire            twoBytes,
    input  wire regDataT   writeData,
    output regDataT        readData,
    output logic           err,
    // Master side
    output slaveAddrT      cmdSlaveAddr,
    output logic           cmdWrite,
    output regAddrT        cmdRegAddr,
    output logic           cmdTwoBytes,
    output regDataT        cmdWriteData,
    output logic           start,
    input  wire            busy,
    input  wire            done,
    input  wire regDataT   masterReadData,
    input  wire            nack
);

    typedef enum logic [1:0] {PortWait, PortBusy, PortAck} portStateT;

    portStateT state;
    logic      accept;

    // New command only once the previous cycle fully closed
    assign accept = (state == PortWait) && req && !busy;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= PortWait;
            start <= 1'b0;
            ack   <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                PortWait: begin
                    if (accept) begin
                        start <= 1'b1;
                        state <= PortBusy;
                    end
                end
                PortBusy: begin
                    if (done) begin
                        ack   <= 1'b1;
                        state <= PortAck;
                    end
                end
                PortAck: begin
                    // Hold ack until the client lets go of req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= PortWait;
                    end
                end
                default: state <= PortWait;
            endcase
        end
    end

    // Command fields and status
    always_ff @(posedge clk) begin
        if (accept) begin
            cmdSlaveAddr <= slaveAddr;
            cmdWrite     <= write;
            cmdRegAddr   <= regAddr;
            cmdTwoBytes  <= twoBytes;
            cmdWriteData <= writeData;
        end
        if (state == PortBusy && done) begin
            readData <= masterReadData;
            err      <= nack;
        end
    end

endmodule

`default_nettype wire

/* hdl/sensorI2cMaster.sv */
`timescale 1ns/1ps
`default_nettype none

module sensorI2cMaster
    import sensorI2cPkg::*;
#(
    parameter int ClkFreq,
    parameter int I2cFreq
) (
    input  wire            clk,
    input  wire            rstN,
    input  wire            start,
    input  wire slaveAddrT slaveAddr,
    input  wire            write,
    input  wire regAddrT   regAddr,
    input  wire            twoBytes,
    input  wire regDataT   writeData,
    output logic           busy,
    output logic           done,
    output regDataT        readData,
    output logic           nack,
    // Open-drain style bus
    output logic           sclOut,
    output logic           sdaLow,
    input  wire            sdaIn
);

    // Quarter of an SCL period, rounded up so the bus is never too fast
    localparam int QuarterCycles = (ClkFreq + 4 * I2cFreq - 1) / (4 * I2cFreq);
    localparam int DelayWidth = (QuarterCycles > 1) ? $clog2(QuarterCycles) : 1;
    localparam logic [DelayWidth-1:0] QuarterLoad = DelayWidth'(QuarterCycles - 1);

    masterStateT state;
    masterStateT nextState;
    logic [DelayWidth-1:0] delay;
    // Low bit is the sentinel, MSB is on the bus
    logic [8:0]  shiftOut;
    // Sentinel walks up to bit 16 (or 8 between bytes)
    logic [16:0] shiftIn;
    logic        mackLow;
    logic        sdaMeta;
    logic        sdaSync;

    assign sdaLow   = ~shiftOut[8];
    assign readData = shiftIn[15:0];

    // ====================
    // SDA input sync
    // ====================
    always_ff @(posedge clk) begin
        sdaMeta <= sdaIn;
        sdaSync <= sdaMeta;
    end

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= StIdle;
            nextState <= StIdle;
            delay     <= '0;
            sclOut    <= 1'b1;
            shiftOut  <= '1;
            shiftIn   <= '0;
            mackLow   <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (delay != '0) begin
                delay <= delay - 1'b1;
            end else begin
                // Every bus step waits one quarter unless told otherwise
                delay <= QuarterLoad;
                case (state)
                    StIdle: begin
                        if (start) begin
                            // Start condition, SDA falls while SCL high
                            shiftOut <= '0;
                            shiftIn  <= '0;
                            busy     <= 1'b1;
                            nack     <= 1'b0;
                            state    <= StStart;
                        end else begin
                            delay <= '0;
                        end
                    end
                    StStart: begin
                        sclOut <= 1'b0;
                        state  <= StAddrW;
                    end
                    // Always write direction first, even for a read
                    StAddrW: begin
                        shiftOut  <= {slaveAddr, 1'b0, 1'b1};
                        nextState <= StRegHi;
                        state     <= StShiftHi;
                    end

                    // Byte shift-out, shared by all transmitted bytes
                    StShiftHi: begin
                        sclOut <= 1'b1;
                        state  <= StShiftHold;
                    end
                    StShiftHold: state <= StShiftFall;
                    StShiftFall: begin
                        sclOut <= 1'b0;
                        state  <= StShiftNext;
                    end
                    StShiftNext: begin
                        if (shiftOut[7:0] != 8'h80) begin
                            shiftOut <= shiftOut << 1;
                            state    <= StShiftHi;
                        end else begin
                            // Release SDA for the slave ACK
                            shiftOut <= '1;
                            state    <= StAckHi;
                        end
                    end
                    StAckHi: begin
                        sclOut <= 1'b1;
                        state  <= StAckSample;
                    end
                    StAckSample: begin
                        if (sdaSync) begin
                            nack <= 1'b1;
                        end
                        state <= StAckFall;
                    end
                    StAckFall: begin
                        sclOut <= 1'b0;
                        if (nack) begin
                            shiftIn <= '0;
                            state   <= StStopLow;
                        end else begin
                            state <= nextState;
                        end
                    end

                    // Register address, then write data
                    StRegHi: begin
                        shiftOut  <= {regAddr[15:8], 1'b1};
                        nextState <= StRegLo;
                        state     <= StShiftHi;
                    end
                    StRegLo: begin
                        shiftOut <= {regAddr[7:0], 1'b1};
                        state    <= StShiftHi;
                        if (!write) begin
                            nextState <= StRestartRel;
                        end else if (twoBytes) begin
                            nextState <= StDataHi;
                        end else begin
                            nextState <= StDataLo;
                        end
                    end
                    StDataHi: begin
                        shiftOut  <= {writeData[15:8], 1'b1};
                        nextState <= StDataLo;
                        state     <= StShiftHi;
                    end
                    StDataLo: begin
                        shiftOut  <= {writeData[7:0], 1'b1};
                        nextState <= StStopLow;
                        state     <= StShiftHi;
                    end

                    // ====================
                    // Repeated start and read
                    // ====================
                    StRestartRel: begin
                        shiftOut <= '1;
                        state    <= StRestartHi;
                    end
                    StRestartHi: begin
                        sclOut <= 1'b1;
                        state  <= StRestartSda;
                    end
                    StRestartSda: begin
                        shiftOut <= '0;
                        state    <= StRestartLow;
                    end
                    StRestartLow: begin
                        sclOut <= 1'b0;
                        state  <= StAddrR;
                    end
                    StAddrR: begin
                        shiftOut  <= {slaveAddr, 1'b1, 1'b1};
                        shiftIn   <= twoBytes ? 17'h00001 : 17'h00100;
                        nextState <= StReadRel;
                        state     <= StShiftHi;
                    end
                    StReadRel: begin
                        shiftOut <= '1;
                        state    <= StReadHi;
                    end
                    StReadHi: begin
                        sclOut <= 1'b1;
                        state  <= StReadSample;
                    end
                    StReadSample: begin
                        shiftIn <= {shiftIn[15:0], sdaSync};
                        state   <= StReadFall;
                    end
                    StReadFall: begin
                        sclOut <= 1'b0;
                        if (shiftIn[16:8] == 9'h001) begin
                            // First of two bytes, master ACKs
                            mackLow   <= 1'b1;
                            nextState <= StReadRel;
                            state     <= StMackDrive;
                        end else if (shiftIn[16]) begin
                            mackLow   <= 1'b0;
                            nextState <= StStopLow;
                            state     <= StMackDrive;
                        end else begin
                            state <= StReadRel;
                        end
                    end
                    StMackDrive: begin
                        shiftOut <= mackLow ? 9'h000 : 9'h1ff;
                        state    <= StMackHi;
                    end
                    StMackHi: begin
                        sclOut <= 1'b1;
                        state  <= StMackHold;
                    end
                    StMackHold: state <= StMackFall;
                    StMackFall: begin
                        sclOut <= 1'b0;
                        state  <= nextState;
                    end

                    // Stop, SDA rises while SCL high
                    StStopLow: begin
                        shiftOut <= '0;
                        state    <= StStopHi;
                    end
                    StStopHi: begin
                        sclOut <= 1'b1;
                        state  <= StStopRel;
                    end
                    StStopRel: begin
                        shiftOut <= '1;
                        state    <= StDone;
                    end
                    // Bus is idle again by now
                    StDone: begin
                        delay <= '0;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= StIdle;
                    end
                    default: state <= StIdle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sensorI2cTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sensorI2cTop
    import sensorI2cPkg::*;
#(
    parameter int ClkFreq = 24_000_000,
    parameter int I2cFreq = 400_000
) (
    input  wire            clk,
    input  wire            rstN,
    input  wire            req,
    output logic           ack,
    input  wire slaveAddrT slaveAddr,
    input  wire            write,
    input  wire regAddrT   regAddr,
    input  wire            twoBytes,
    input  wire regDataT   writeData,
    output regDataT        readData,
    output logic           err,
    output logic           sclOut,
    output logic           sdaLow,
    input  wire            sdaIn
);

    // ====================
    // Port to master
    // ====================
    slaveAddrT cmdSlaveAddr;
    regAddrT   cmdRegAddr;
    regDataT   cmdWriteData;
    regDataT   masterReadData;
    logic      cmdWrite;
    logic      cmdTwoBytes;
    logic      start;
    logic      busy;
    logic      done;
    logic      nack;

    i2cCmdPort i2cCmdPort_i (
        .clk           (clk),
        .rstN          (rstN),
        .req           (req),
        .ack           (ack),
        .slaveAddr     (slaveAddr),
        .write         (write),
        .regAddr       (regAddr),
        .twoBytes      (twoBytes),
        .writeData     (writeData),
        .readData      (readData),
        .err           (err),
        .cmdSlaveAddr  (cmdSlaveAddr),
        .cmdWrite      (cmdWrite),
        .cmdRegAddr    (cmdRegAddr),
        .cmdTwoBytes   (cmdTwoBytes),
        .cmdWriteData  (cmdWriteData),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .masterReadData(masterReadData),
        .nack          (nack)
    );

    sensorI2cMaster #(
        .ClkFreq(ClkFreq),
        .I2cFreq(I2cFreq)
    ) sensorI2cMaster_i (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .slaveAddr(cmdSlaveAddr),
        .write    (cmdWrite),
        .regAddr  (cmdRegAddr),
        .twoBytes (cmdTwoBytes),
        .writeData(cmdWriteData),
        .busy     (busy),
        .done     (done),
        .readData (masterReadData),
        .nack     (nack),
        .sclOut   (sclOut),
        .sdaLow   (sdaLow),
        .sdaIn    (sdaIn)
    );

endmodule

`default_nettype wire

/* sim/i2cSensorModel.sv */
`timescale 1ns/1ps
`default_nettype none

module i2cSensorModel
    import sensorI2cPkg::*;
#(
    parameter slaveAddrT SlaveAddr = 7'h36
) (
    input  wire  clk,
    input  wire  rstN,
    input  wire  scl,
    input  wire  sda,
    output logic sdaLow
);

    logic [7:0] regFile [256];
    logic [7:0] pointer;
    logic [7:0] rxByte;
    logic [7:0] txByte;
    logic       sclPrev;
    logic       sdaPrev;
    logic       active;
    logic       reading;
    logic       sending;
    logic       masterAck;
    logic       ackIt;
    int         bitCnt;
    int         byteIdx;

    // Bus sampled on the system clock, edges found against the previous sample
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                regFile[i[7:0]] = 8'h00;
            end
            pointer = 8'h00;
            rxByte  = 8'h00;
            txByte  = 8'h00;
            sclPrev = 1'b1;
            sdaPrev = 1'b1;
            active  = 1'b0;
            reading = 1'b0;
            sending = 1'b0;
            bitCnt  = 0;
            byteIdx = 0;
            sdaLow  <= 1'b0;
        end else begin
            if (scl && sclPrev && sdaPrev && !sda) begin
                // Start or repeated start
                active  = 1'b1;
                reading = 1'b0;
                sending = 1'b0;
                bitCnt  = 0;
                byteIdx = 0;
                sdaLow  <= 1'b0;
            end else if (scl && sclPrev && !sdaPrev && sda) begin
                // Stop
                active  = 1'b0;
                sending = 1'b0;
                sdaLow  <= 1'b0;
            end else if (active && scl && !sclPrev) begin
                bitCnt = bitCnt + 1;
                if (bitCnt <= 8 && !sending) begin
                    rxByte = {rxByte[6:0], sda};
                end else if (bitCnt == 9 && sending) begin
                    masterAck = !sda;
                end
            end else if (active && !scl && sclPrev) begin
                if (bitCnt == 8 && sending) begin
                    // Master owns SDA for its ACK
                    sdaLow  <= 1'b0;
                    pointer = pointer + 8'd1;
                end else if (bitCnt == 8) begin
                    ackIt = 1'b1;
                    case (byteIdx)
                        0: begin
                            ackIt   = (rxByte[7:1] == SlaveAddr);
                            reading = rxByte[0];
                            active  = ackIt;
                        end
                        1: ;
                        2: pointer = rxByte;
                        default: begin
                            regFile[pointer] = rxByte;
                            pointer = pointer + 8'd1;
                        end
                    endcase
                    sdaLow <= ackIt;
                end else if (bitCnt == 9) begin
                    bitCnt = 0;
                    if (sending && !masterAck) begin
                        // Master NACK ends the read
                        sending = 1'b0;
                        active  = 1'b0;
                        sdaLow  <= 1'b0;
                    end else if (sending || (byteIdx == 0 && reading)) begin
                        sending = 1'b1;
                        txByte  = regFile[pointer];
                        sdaLow  <= !txByte[7];
                    end else begin
                        sdaLow <= 1'b0;
                    end
                    byteIdx = byteIdx + 1;
                end else if (sending && bitCnt >= 1 && bitCnt <= 7) begin
                    txByte = txByte << 1;
                    sdaLow <= !txByte[7];
                end
            end
            sclPrev = scl;
            sdaPrev = sda;
        end
    end

endmodule

`default_nettype wire

/* sim/sensorI2cMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

module sensorI2cMonitor
    import sensorI2cPkg::*;
#(
    parameter slaveAddrT SensorAddr = 7'h36
) (
    input  wire            clk,
    input  wire            rstN,
    input  wire            req,
    input  wire            ack,
    input  wire slaveAddrT slaveAddr,
    input  wire            write,
    input  wire regAddrT   regAddr,
    input  wire            twoBytes,
    input  wire regDataT   writeData,
    input  wire regDataT   readData,
    input  wire            err,
    input  wire            sclOut,
    input  wire            sdaLow,
    output int             errorCount,
    output int             checkCount
);

    // Shadow of the sensor register file
    logic [7:0] shadow [256];
    logic       cmdValid;
    logic       ackPrev;
    slaveAddrT  cmdAddr;
    logic       cmdWrite;
    logic       cmdTwo;
    logic [7:0] cmdPtr;
    regDataT    cmdData;

    always @(posedge clk) begin : compareBlock
        logic    expErr;
        regDataT expData;
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                shadow[i[7:0]] = 8'h00;
            end
            cmdValid   = 1'b0;
            ackPrev    = 1'b0;
            errorCount = 0;
            checkCount = 0;
        end else begin
            // Fields are held by the client while req is high
            if (req && !ack && !cmdValid) begin
                cmdAddr  = slaveAddr;
                cmdWrite = write;
                cmdTwo   = twoBytes;
                cmdPtr   = regAddr[7:0];
                cmdData  = writeData;
                cmdValid = 1'b1;
            end
            if (ack && !ackPrev) begin
                if (!cmdValid) begin
                    $display("ack rose at %0t without a pending command", $time);
                    errorCount++;
                end else begin
                    checkCount++;
                    expErr = (cmdAddr != SensorAddr);
                    if (err !== expErr) begin
                        $display("** Error: err = %h, expected %h (slaveAddr %h)",
                                 err, expErr, cmdAddr);
                        errorCount++;
                    end
                    if (sclOut !== 1'b1 || sdaLow !== 1'b0) begin
                        $display("Bus was not idle when ack rose at %0t", $time);
                        errorCount++;
                    end
                    if (!expErr && cmdWrite && cmdTwo) begin
                        shadow[cmdPtr]         = cmdData[15:8];
                        shadow[cmdPtr + 8'd1]  = cmdData[7:0];
                    end else if (!expErr && cmdWrite) begin
                        shadow[cmdPtr] = cmdData[7:0];
                    end else if (!expErr) begin
                        // High byte first on a two-byte read
                        expData = cmdTwo ? {shadow[cmdPtr], shadow[cmdPtr + 8'd1]}
                                         : {8'h00, shadow[cmdPtr]};
                        if (readData !== expData) begin
                            $display("** Error: readData = %h, expected %h (regAddr low %h)",
                                     readData, expData, cmdPtr);
                            errorCount++;
                        end
                    end
                end
                cmdValid = 1'b0;
            end
            ackPrev = ack;
        end
    end

endmodule

`default_nettype wire

/* sim/sensorI2c_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sensorI2c_checker
    import sensorI2cPkg::*;
(
    input wire              clk,
    input wire              rstN,
    input wire              req,
    input wire              ack,
    input wire regDataT     readData,
    input wire              err,
    input wire              done,
    input wire              sclOut,
    input wire              sdaLow,
    input wire              sdaIn,
    input wire masterStateT masterState
);

    int assertFails = 0;

    // Bus released and master idle right after reset
    resetIdle: assert property (@(posedge clk)
        !rstN |=> sclOut && !sdaLow && masterState == StIdle)
    else begin
        $error("bus not idle after reset");
        assertFails++;
    end

    // ====================
    // Handshake
    // ====================
    ackAfterDone: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(done))
    else begin
        $error("ack rose without a finished transaction");
        assertFails++;
    end

    ackHeld: assert property (@(posedge clk) disable iff (!rstN)
        ack && req |=> ack)
    else begin
        $error("ack dropped while req was high");
        assertFails++;
    end

    ackFallsAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $fell(ack) |-> !$past(req))
    else begin
        $error("ack fell before req fell");
        assertFails++;
    end

    statusStable: assert property (@(posedge clk) disable iff (!rstN)
        ack && $past(ack) |-> $stable(readData) && $stable(err))
    else begin
        $error("status changed while ack was high");
        assertFails++;
    end

    // SDA moves under a high SCL only for start, repeated start or stop
    sdaFraming: assert property (@(posedge clk) disable iff (!rstN)
        sclOut && $past(sclOut) && (sdaIn != $past(sdaIn))
            |-> masterState inside {StStart, StRestartLow, StDone})
    else begin
        $error("SDA changed while SCL was high");
        assertFails++;
    end

endmodule

`default_nettype wire

/* sim/sensorI2cTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sensorI2cTb
    import sensorI2cPkg::*;
();

    localparam int ClkFreq = 125_000_000;
    localparam int I2cFreq = 12_500_000;
    localparam slaveAddrT SensorAddr = 7'h36;
    localparam int NumCmds = 40;
    localparam int QuarterCycles = (ClkFreq + 4 * I2cFreq - 1) / (4 * I2cFreq);
    // Longest transaction stays under 250 quarters and the handshake gaps fit in the margin
    localparam int TimeoutCycles = NumCmds * 250 * QuarterCycles + 2000;

    logic      clk = 1'b0;
    logic      rstN;
    logic      req;
    logic      ack;
    slaveAddrT slaveAddr;
    logic      write;
    regAddrT   regAddr;
    logic      twoBytes;
    regDataT   writeData;
    regDataT   readData;
    logic      err;
    logic      sclOut;
    logic      sdaLow;
    logic      modelSdaLow;
    logic      sdaBus;
    int        monErrors;
    int        monChecks;
    int        cycleCount = 0;
    int        cmdCount = 0;
    integer    seed;

    always #4 clk = ~clk;

    // Wired-AND of both open-drain drivers
    assign sdaBus = !(sdaLow || modelSdaLow);

    sensorI2cTop #(
        .ClkFreq(ClkFreq),
        .I2cFreq(I2cFreq)
    ) sensorI2cTop_i (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .ack      (ack),
        .slaveAddr(slaveAddr),
        .write    (write),
        .regAddr  (regAddr),
        .twoBytes (twoBytes),
        .writeData(writeData),
        .readData (readData),
        .err      (err),
        .sclOut   (sclOut),
        .sdaLow   (sdaLow),
        .sdaIn    (sdaBus)
    );

    i2cSensorModel #(
        .SlaveAddr(SensorAddr)
    ) sensorModel_i (
        .clk   (clk),
        .rstN  (rstN),
        .scl   (sclOut),
        .sda   (sdaBus),
        .sdaLow(modelSdaLow)
    );

    sensorI2cMonitor #(
        .SensorAddr(SensorAddr)
    ) monitor_i (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .ack       (ack),
        .slaveAddr (slaveAddr),
        .write     (write),
        .regAddr   (regAddr),
        .twoBytes  (twoBytes),
        .writeData (writeData),
        .readData  (readData),
        .err       (err),
        .sclOut    (sclOut),
        .sdaLow    (sdaLow),
        .errorCount(monErrors),
        .checkCount(monChecks)
    );

    bind sensorI2cTop sensorI2c_checker busChecker_i (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .ack        (ack),
        .readData   (readData),
        .err        (err),
        .done       (done),
        .sclOut     (sclOut),
        .sdaLow     (sdaLow),
        .sdaIn      (sdaIn),
        .masterState(sensorI2cMaster_i.state)
    );

    // ====================
    // Stimulus
    // ====================
    task automatic runCommand();
        logic [31:0] rnd;
        logic [31:0] holdRnd;
        logic [31:0] gapRnd;
        rnd = $random(seed);
        @(negedge clk);
        // Roughly one in eight goes to an absent device
        if (rnd[2:0] == 3'd0) begin
            slaveAddr = (rnd[9:3] == SensorAddr) ? (SensorAddr ^ 7'h01) : rnd[9:3];
        end else begin
            slaveAddr = SensorAddr;
        end
        write     = rnd[10];
        twoBytes  = rnd[11];
        regAddr   = {8'h30, 5'b00000, rnd[14:12]};
        writeData = rnd[31:16];
        req       = 1'b1;
        cmdCount++;
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        // Keep req high a few cycles so ack and the status must hold against it
        holdRnd = $random(seed);
        repeat (holdRnd[2:0] + 1) @(negedge clk);
        req = 1'b0;
        while (ack !== 1'b0) begin
            @(negedge clk);
        end
        gapRnd = $random(seed);
        repeat (gapRnd[3:0]) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, a transaction never completed", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int assertFails;
        int totalErrors;
        seed      = 32'ha7b5_7569;
        rstN      = 1'b0;
        req       = 1'b0;
        slaveAddr = '0;
        write     = 1'b0;
        regAddr   = '0;
        twoBytes  = 1'b0;
        writeData = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        repeat (4) @(negedge clk);
        for (int i = 0; i < NumCmds; i++) begin
            runCommand();
        end
        repeat (10) @(negedge clk);
        assertFails = sensorI2cTop_i.busChecker_i.assertFails;
        totalErrors = monErrors + assertFails;
        if (monChecks != NumCmds) begin
            $display("Only %0d of %0d commands reached a status check", monChecks, NumCmds);
            totalErrors++;
        end
        $display("Commands %0d, checked %0d, monitor errors %0d, assertion failures %0d",
                 cmdCount, monChecks, monErrors, assertFails);
        if (totalErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/sensorI2cPkg.sv
hdl/i2cCmdPort.sv
hdl/sensorI2cMaster.sv
hdl/sensorI2cTop.sv
sim/i2cSensorModel.sv
sim/sensorI2cMonitor.sv
sim/sensorI2c_checker.sv
sim/sensorI2cTb.sv

/* Makefile */
# Verilator build and run of the sensor I2C master testbench

SOURCES := $(shell cat sim.f)

obj_dir/VsensorI2cTb: sim.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps --top-module sensorI2cTb \
		-f sim.f -Mdir obj_dir -o VsensorI2cTb

.PHONY: build run clean

build: obj_dir/VsensorI2cTb

run: obj_dir/VsensorI2cTb
	@out="$$(./obj_dir/VsensorI2cTb +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf obj_dir
